// File: bp_pkg.sv
package bp_pkg;

	////////////////////
	// Widths
	////////////////////

	parameter int XLEN = 32; // PC, instruction word and target

	parameter int RAS_PTR_W = 3; // Top-of-stack pointer, 8 entries

	// Link registers per the RISC-V calling convention
	parameter logic [4:0] LINK_X1 = 5'd1; // ra
	parameter logic [4:0] LINK_X5 = 5'd5; // t0, alternate link

	////////////////////
	// Major opcodes
	////////////////////

	typedef enum logic [6:0] {
		OP_BRANCH = 7'b1100011, // B-type
		OP_JALR   = 7'b1100111, // Indirect jump
		OP_JAL    = 7'b1101111, // Direct jump
		OP_OTHER  = 7'b0010011  // Stand-in for anything else
	} opcode_e;

	////////////////////
	// Direction counter
	////////////////////

	// Upper bit is the taken prediction
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} counter_e;

endpackage

// File: branch_predict.f
bp_pkg.sv
gshare_predictor.sv
jalr_target_cache.sv
return_address_stack.sv
jump_controller.sv
branch_predict_top.sv
tb_branch_predict.sv

// File: branch_predict_top.sv
`timescale 1ns/1ps

module branch_predict_top import bp_pkg::*; #(
	parameter int ADDR_WIDTH    = XLEN,
	parameter int ENTRIES       = 32,
	parameter int CACHE_ENTRIES = 16,
	parameter int RAS_DEPTH     = 8
)(
	input  logic                       clk,
	input  logic                       reset_i,

	input  logic                       base_valid_i,
	input  logic [ADDR_WIDTH-1:0]      pc_0_i,
	input  logic [ADDR_WIDTH-1:0]      pc_1_i,
	input  logic [ADDR_WIDTH-1:0]      instr_0_i,
	input  logic [ADDR_WIDTH-1:0]      instr_1_i,

	input  logic                       update_valid_i,
	input  logic [ADDR_WIDTH-1:0]      update_pc_i,
	input  logic                       update_taken_i,
	input  logic [$clog2(ENTRIES)-1:0] update_ghist_i,

	input  logic                       jalr_update_valid_i,
	input  logic [ADDR_WIDTH-1:0]      jalr_update_pc_i,
	input  logic [ADDR_WIDTH-1:0]      correct_pc_i,

	input  logic                       ras_restore_en_i,
	input  logic [RAS_PTR_W-1:0]       ras_restore_tos_i,

	output logic                       jump_0_o, // Taken
	output logic                       jump_1_o,
	output logic                       jalr_0_o,
	output logic                       jalr_1_o,
	output logic [$clog2(ENTRIES)-1:0] ghist_0_o, // Travels with the branch to execute
	output logic [$clog2(ENTRIES)-1:0] ghist_1_o,
	output logic                       jalr_pred_valid_o,
	output logic [ADDR_WIDTH-1:0]      jalr_pred_target_o,
	output logic [RAS_PTR_W-1:0]       ras_tos_checkpoint_o
);

	jump_controller #(
		.ADDR_WIDTH    (ADDR_WIDTH),
		.ENTRIES       (ENTRIES),
		.CACHE_ENTRIES (CACHE_ENTRIES),
		.RAS_DEPTH     (RAS_DEPTH)
	) u_jump_controller (
		.clk                  (clk),
		.reset_i              (reset_i),
		.base_valid_i         (base_valid_i),
		.pc_0_i               (pc_0_i),
		.pc_1_i               (pc_1_i),
		.instr_0_i            (instr_0_i),
		.instr_1_i            (instr_1_i),
		.update_valid_i       (update_valid_i),
		.update_pc_i          (update_pc_i),
		.update_taken_i       (update_taken_i),
		.update_ghist_i       (update_ghist_i),
		.jalr_update_valid_i  (jalr_update_valid_i),
		.jalr_update_pc_i     (jalr_update_pc_i),
		.correct_pc_i         (correct_pc_i),
		.ras_restore_en_i     (ras_restore_en_i),
		.ras_restore_tos_i    (ras_restore_tos_i),
		.jump_0_o             (jump_0_o),
		.jump_1_o             (jump_1_o),
		.jalr_0_o             (jalr_0_o),
		.jalr_1_o             (jalr_1_o),
		.ghist_0_o            (ghist_0_o),
		.ghist_1_o            (ghist_1_o),
		.jalr_pred_valid_o    (jalr_pred_valid_o),
		.jalr_pred_target_o   (jalr_pred_target_o),
		.ras_tos_checkpoint_o (ras_tos_checkpoint_o)
	);

endmodule

// File: gshare_predictor.sv
`timescale 1ns/1ps

module gshare_predictor import bp_pkg::*; #(
	parameter int ADDR_WIDTH = XLEN,
	parameter int ENTRIES    = 32
)(
	input  logic                       clk,
	input  logic                       reset_i,

	// Lookup, one per fetch slot
	input  logic [ADDR_WIDTH-1:0]      lookup_pc_0_i,
	input  logic [ADDR_WIDTH-1:0]      lookup_pc_1_i,
	output logic                       taken_0_o,
	output logic                       taken_1_o,
	output logic [$clog2(ENTRIES)-1:0] ghist_o,

	// Resolve from execute
	input  logic                       update_valid_i,
	input  logic [ADDR_WIDTH-1:0]      update_pc_i,
	input  logic                       update_taken_i,
	input  logic [$clog2(ENTRIES)-1:0] update_ghist_i
);

	localparam int HIST_W = $clog2(ENTRIES);

	counter_e          pht [ENTRIES]; // Pattern history table
	logic [HIST_W-1:0] ghist;

	logic [HIST_W-1:0] idx_0;
	logic [HIST_W-1:0] idx_1;
	logic [HIST_W-1:0] upd_idx;
	counter_e          upd_cnt;
	counter_e          upd_next;

	// Word address xor history
	assign idx_0   = lookup_pc_0_i[HIST_W+1:2] ^ ghist;
	assign idx_1   = lookup_pc_1_i[HIST_W+1:2] ^ ghist;
	assign upd_idx = update_pc_i[HIST_W+1:2] ^ update_ghist_i; // History the branch saw at fetch

	assign taken_0_o = pht[idx_0][1];
	assign taken_1_o = pht[idx_1][1];
	assign ghist_o   = ghist;

	assign upd_cnt = pht[upd_idx];

	// Saturating step toward the outcome
	always_comb begin
		upd_next = upd_cnt;
		case (upd_cnt)
			STRONG_NT: upd_next = update_taken_i ? WEAK_NT : STRONG_NT;
			WEAK_NT:   upd_next = update_taken_i ? WEAK_T : STRONG_NT;
			WEAK_T:    upd_next = update_taken_i ? STRONG_T : WEAK_NT;
			STRONG_T:  upd_next = update_taken_i ? STRONG_T : WEAK_T;
			default:   upd_next = WEAK_NT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				pht[i] <= WEAK_NT;
			end
		end else if (update_valid_i) begin
			pht[upd_idx] <= upd_next;
		end
	end

	// Outcome shifts in at the bottom
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ghist <= '0;
		end else if (update_valid_i) begin
			ghist <= {ghist[HIST_W-2:0], update_taken_i};
		end
	end

endmodule

// File: jalr_target_cache.sv
`timescale 1ns/1ps

module jalr_target_cache import bp_pkg::*; #(
	parameter int ADDR_WIDTH    = XLEN,
	parameter int CACHE_ENTRIES = 16
)(
	input  logic                  clk,
	input  logic                  reset_i,

	input  logic [ADDR_WIDTH-1:0] lookup_pc_i,
	output logic                  hit_o,
	output logic [ADDR_WIDTH-1:0] target_o,

	// Resolved JALR from execute
	input  logic                  wr_valid_i,
	input  logic [ADDR_WIDTH-1:0] wr_pc_i,
	input  logic [ADDR_WIDTH-1:0] wr_target_i
);

	localparam int IDX_W = $clog2(CACHE_ENTRIES);
	localparam int TAG_W = ADDR_WIDTH - IDX_W - 2;

	logic [CACHE_ENTRIES-1:0] valid;
	logic [TAG_W-1:0]         tag_mem    [CACHE_ENTRIES];
	logic [ADDR_WIDTH-1:0]    target_mem [CACHE_ENTRIES];

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;

	assign rd_idx = lookup_pc_i[IDX_W+1:2];
	assign rd_tag = lookup_pc_i[ADDR_WIDTH-1:IDX_W+2];
	assign wr_idx = wr_pc_i[IDX_W+1:2];

	assign hit_o    = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign target_o = target_mem[rd_idx];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid <= '0;
		end else if (wr_valid_i) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	// Last target wins, no replacement policy
	always_ff @(posedge clk) begin
		if (wr_valid_i) begin
			tag_mem[wr_idx]    <= wr_pc_i[ADDR_WIDTH-1:IDX_W+2];
			target_mem[wr_idx] <= wr_target_i;
		end
	end

endmodule

// File: jump_controller.sv
`timescale 1ns/1ps

module jump_controller import bp_pkg::*; #(
	parameter int ADDR_WIDTH    = XLEN,
	parameter int ENTRIES       = 32,
	parameter int CACHE_ENTRIES = 16,
	parameter int RAS_DEPTH     = 8
)(
	input  logic                       clk,
	input  logic                       reset_i,

	// Fetch group
	input  logic                       base_valid_i,
	input  logic [ADDR_WIDTH-1:0]      pc_0_i,
	input  logic [ADDR_WIDTH-1:0]      pc_1_i,
	input  logic [ADDR_WIDTH-1:0]      instr_0_i,
	input  logic [ADDR_WIDTH-1:0]      instr_1_i,

	// Branch resolve
	input  logic                       update_valid_i,
	input  logic [ADDR_WIDTH-1:0]      update_pc_i,
	input  logic                       update_taken_i,
	input  logic [$clog2(ENTRIES)-1:0] update_ghist_i,

	// JALR resolve
	input  logic                       jalr_update_valid_i,
	input  logic [ADDR_WIDTH-1:0]      jalr_update_pc_i,
	input  logic [ADDR_WIDTH-1:0]      correct_pc_i,

	input  logic                       ras_restore_en_i,
	input  logic [RAS_PTR_W-1:0]       ras_restore_tos_i,

	// Predictions
	output logic                       jump_0_o,
	output logic                       jump_1_o,
	output logic                       jalr_0_o,
	output logic                       jalr_1_o,
	output logic [$clog2(ENTRIES)-1:0] ghist_0_o,
	output logic [$clog2(ENTRIES)-1:0] ghist_1_o,
	output logic                       jalr_pred_valid_o,
	output logic [ADDR_WIDTH-1:0]      jalr_pred_target_o,
	output logic [RAS_PTR_W-1:0]       ras_tos_checkpoint_o
);

	function automatic logic is_link(input logic [4:0] r);
		return (r == LINK_X1) || (r == LINK_X5);
	endfunction

	opcode_e op_0, op_1;
	logic    is_jal_0, is_br_0, is_jalr_0;
	logic    is_jal_1, is_br_1, is_jalr_1;
	logic    taken_0, taken_1;
	logic    block_1;
	logic    call_0, call_1, ret_0, ret_1;
	logic    sel_ret;

	logic [$clog2(ENTRIES)-1:0] ghist;
	logic                       cache_hit;
	logic [ADDR_WIDTH-1:0]      cache_target;
	logic [ADDR_WIDTH-1:0]      ras_top;
	logic                       ras_nonempty;
	logic                       ras_push;
	logic                       ras_pop;
	logic [ADDR_WIDTH-1:0]      ras_push_addr;

	////////////////////
	// Slot decode
	////////////////////

	assign op_0 = opcode_e'(instr_0_i[6:0]);
	assign op_1 = opcode_e'(instr_1_i[6:0]);

	assign is_jal_0  = (op_0 == OP_JAL);
	assign is_br_0   = (op_0 == OP_BRANCH);
	assign is_jalr_0 = (op_0 == OP_JALR);
	assign is_jal_1  = (op_1 == OP_JAL);
	assign is_br_1   = (op_1 == OP_BRANCH);
	assign is_jalr_1 = (op_1 == OP_JALR);

	assign jump_0_o = base_valid_i & (is_jal_0 | (is_br_0 & taken_0));
	assign jalr_0_o = base_valid_i & is_jalr_0;

	// Anything redirecting in slot 0 kills slot 1
	assign block_1  = ~base_valid_i | jump_0_o | jalr_0_o;
	assign jump_1_o = ~block_1 & (is_jal_1 | (is_br_1 & taken_1));
	assign jalr_1_o = ~block_1 & is_jalr_1;

	assign ghist_0_o = ghist; // Same history for both slots
	assign ghist_1_o = ghist;

	////////////////////
	// Calls and returns
	////////////////////

	assign call_0 = base_valid_i & (is_jal_0 | is_jalr_0) & is_link(instr_0_i[11:7]);
	assign call_1 = ~block_1 & (is_jal_1 | is_jalr_1) & is_link(instr_1_i[11:7]);
	assign ret_0  = jalr_0_o & is_link(instr_0_i[19:15]) & (instr_0_i[11:7] == 5'd0);
	assign ret_1  = jalr_1_o & is_link(instr_1_i[19:15]) & (instr_1_i[11:7] == 5'd0);

	assign ras_push      = call_0 | call_1;
	assign ras_pop       = ret_0 | ret_1;
	assign ras_push_addr = call_0 ? pc_0_i + ADDR_WIDTH'(4) : pc_1_i + ADDR_WIDTH'(4);

	// First unblocked JALR owns the target
	assign sel_ret = jalr_0_o ? ret_0 : ret_1;

	always_comb begin
		jalr_pred_valid_o  = 1'b0;
		jalr_pred_target_o = cache_target;
		if (jalr_0_o || jalr_1_o) begin
			if (sel_ret && ras_nonempty) begin
				jalr_pred_valid_o  = 1'b1;
				jalr_pred_target_o = ras_top;
			end else begin
				jalr_pred_valid_o = cache_hit;
			end
		end
	end

	gshare_predictor #(.ADDR_WIDTH(ADDR_WIDTH), .ENTRIES(ENTRIES)) u_gshare (
		.clk            (clk),
		.reset_i        (reset_i),
		.lookup_pc_0_i  (pc_0_i),
		.lookup_pc_1_i  (pc_1_i),
		.taken_0_o      (taken_0),
		.taken_1_o      (taken_1),
		.ghist_o        (ghist),
		.update_valid_i (update_valid_i),
		.update_pc_i    (update_pc_i),
		.update_taken_i (update_taken_i),
		.update_ghist_i (update_ghist_i)
	);

	jalr_target_cache #(.ADDR_WIDTH(ADDR_WIDTH), .CACHE_ENTRIES(CACHE_ENTRIES)) u_jalr_cache (
		.clk         (clk),
		.reset_i     (reset_i),
		.lookup_pc_i (jalr_0_o ? pc_0_i : pc_1_i),
		.hit_o       (cache_hit),
		.target_o    (cache_target),
		.wr_valid_i  (jalr_update_valid_i),
		.wr_pc_i     (jalr_update_pc_i),
		.wr_target_i (correct_pc_i)
	);

	return_address_stack #(.ADDR_WIDTH(ADDR_WIDTH), .RAS_DEPTH(RAS_DEPTH)) u_ras (
		.clk           (clk),
		.reset_i       (reset_i),
		.push_i        (ras_push),
		.pop_i         (ras_pop),
		.push_addr_i   (ras_push_addr),
		.restore_en_i  (ras_restore_en_i),
		.restore_tos_i (ras_restore_tos_i),
		.top_o         (ras_top),
		.nonempty_o    (ras_nonempty),
		.tos_o         (ras_tos_checkpoint_o)
	);

	a_one_jalr: assert property (@(posedge clk) disable iff (reset_i)
		!(jalr_0_o && jalr_1_o));

endmodule

// File: return_address_stack.sv
`timescale 1ns/1ps

module return_address_stack import bp_pkg::*; #(
	parameter int ADDR_WIDTH = XLEN,
	parameter int RAS_DEPTH  = 8
)(
	input  logic                  clk,
	input  logic                  reset_i,

	input  logic                  push_i,
	input  logic                  pop_i,
	input  logic [ADDR_WIDTH-1:0] push_addr_i, // Return address of the call

	// Misprediction recovery
	input  logic                  restore_en_i,
	input  logic [RAS_PTR_W-1:0]  restore_tos_i,

	output logic [ADDR_WIDTH-1:0] top_o,
	output logic                  nonempty_o,
	output logic [RAS_PTR_W-1:0]  tos_o
);

	localparam int CNT_W = $clog2(RAS_DEPTH + 1);

	if (RAS_DEPTH > (1 << RAS_PTR_W)) begin : g_depth_check
		$error("RAS_DEPTH does not fit the top pointer");
	end

	logic [ADDR_WIDTH-1:0] stack [RAS_DEPTH];
	logic [RAS_PTR_W-1:0]  ptr;
	logic [RAS_PTR_W-1:0]  ptr_inc;
	logic [RAS_PTR_W-1:0]  ptr_dec;
	logic [CNT_W-1:0]      count;

	// Wrap modulo RAS_DEPTH
	assign ptr_inc = (ptr == RAS_PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr + 1'b1;
	assign ptr_dec = (ptr == '0) ? RAS_PTR_W'(RAS_DEPTH - 1) : ptr - 1'b1;

	assign top_o      = stack[ptr];
	assign nonempty_o = (count != '0);
	assign tos_o      = ptr;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ptr   <= '0;
			count <= '0;
		end else if (restore_en_i) begin
			ptr <= restore_tos_i; // Count left as is
		end else if (push_i) begin
			ptr <= ptr_inc;
			if (count != CNT_W'(RAS_DEPTH)) count <= count + 1'b1; // Oldest entry overwritten when full
		end else if (pop_i) begin
			ptr <= ptr_dec;
			if (count != '0) count <= count - 1'b1;
		end
	end

	// Pop leaves the entry in place
	always_ff @(posedge clk) begin
		if (push_i && !restore_en_i) begin
			stack[ptr_inc] <= push_addr_i;
		end
	end

	// Controller only ever issues one stack op per group
	a_push_pop_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(push_i && pop_i));

endmodule

// File: tb_branch_predict.sv
`timescale 1ns/1ps

module tb_branch_predict import bp_pkg::*; ();

	localparam int HIST_W = 5; // log2 of 32 gshare entries
	localparam int IDX_W  = 4; // 16 cache entries

	logic        clk, reset_i, base_valid_i;
	logic [31:0] pc_0_i, pc_1_i, instr_0_i, instr_1_i;
	logic        update_valid_i, update_taken_i;
	logic [31:0] update_pc_i;
	logic [4:0]  update_ghist_i;
	logic        jalr_update_valid_i;
	logic [31:0] jalr_update_pc_i, correct_pc_i;
	logic        ras_restore_en_i;
	logic [2:0]  ras_restore_tos_i;
	logic        jump_0_o, jump_1_o, jalr_0_o, jalr_1_o, jalr_pred_valid_o;
	logic [4:0]  ghist_0_o, ghist_1_o;
	logic [31:0] jalr_pred_target_o;
	logic [2:0]  ras_tos_checkpoint_o;

	// Reference model state
	counter_e    m_pht [32];
	logic [4:0]  m_ghist;
	logic        m_valid [16];
	logic [25:0] m_tag [16];
	logic [31:0] m_target [16];
	logic [31:0] m_stack [8];
	logic [2:0]  m_ptr;
	int          m_count;

	branch_predict_top #(.ADDR_WIDTH(32), .ENTRIES(32), .CACHE_ENTRIES(16), .RAS_DEPTH(8)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic compare_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	function automatic logic link_reg(input logic [4:0] r);
		return (r == LINK_X1) || (r == LINK_X5);
	endfunction

	// One step toward the outcome, saturating at either end
	function automatic counter_e step_counter(input counter_e c, input logic taken);
		if (taken) return (c == STRONG_T) ? c : counter_e'(c + 2'd1);
		return (c == STRONG_NT) ? c : counter_e'(c - 2'd1);
	endfunction

	function automatic logic [31:0] make_instr(input opcode_e op, input logic [4:0] rd,
			input logic [4:0] rs1);
		logic [31:0] w;
		w = $urandom;
		return {w[31:20], rs1, w[14:12], rd, op};
	endfunction

	function automatic logic [4:0] pick_reg();
		case ($urandom % 4)
			0: return 5'd0;
			1: return LINK_X1;
			2: return LINK_X5;
			default: return 5'($urandom);
		endcase
	endfunction

	// Two tags share the whole index range, so lookups alias
	function automatic logic [31:0] alias_pc();
		return {(($urandom % 2) ? 26'h40 : 26'h80), 4'($urandom % 16), 2'b00};
	endfunction

	function automatic logic [31:0] rand_instr(input logic branches_only);
		opcode_e op;
		case (branches_only ? 2 : $urandom % 4)
			0: op = OP_JAL;
			1: op = OP_JALR;
			2: op = OP_BRANCH;
			default: op = OP_OTHER;
		endcase
		return make_instr(op, pick_reg(), pick_reg());
	endfunction

	task automatic next_cycle();
		@(negedge clk);
		base_valid_i        = 1'b0;
		update_valid_i      = 1'b0;
		jalr_update_valid_i = 1'b0;
		ras_restore_en_i    = 1'b0;
	endtask

	task automatic random_fetch(input logic branches_only);
		base_valid_i = branches_only || (($urandom % 4) != 0);
		pc_0_i       = branches_only ? ($urandom & 32'hffff_fffc) : alias_pc();
		pc_1_i       = pc_0_i + 32'd4;
		instr_0_i    = rand_instr(branches_only);
		instr_1_i    = rand_instr(branches_only);
	endtask

	task automatic random_resolve();
		update_valid_i      = ($urandom % 4) != 0;
		update_pc_i         = $urandom;
		update_taken_i      = $urandom;
		update_ghist_i      = ($urandom % 2) ? m_ghist : 5'($urandom); // Mostly in-order
		jalr_update_valid_i = $urandom % 2;
		jalr_update_pc_i    = alias_pc();
		correct_pc_i        = $urandom & 32'hffff_fffc;
	endtask

	task automatic fetch_call(input logic [31:0] pc, input logic use_jalr);
		base_valid_i = 1'b1;
		pc_0_i       = pc;
		pc_1_i       = pc + 32'd4;
		instr_0_i    = use_jalr ? make_instr(OP_JALR, LINK_X5, 5'd7) : make_instr(OP_JAL, LINK_X1, 5'd0);
		instr_1_i    = make_instr(OP_OTHER, 5'd3, 5'd3);
	endtask

	task automatic fetch_return(input logic [31:0] pc, input logic [4:0] link);
		base_valid_i = 1'b1;
		pc_0_i       = pc;
		pc_1_i       = pc + 32'd4;
		instr_0_i    = make_instr(OP_JALR, 5'd0, link);
		instr_1_i    = make_instr(OP_JAL, LINK_X1, 5'd0); // Blocked
	endtask

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		while (ras_tos_checkpoint_o !== 3'd0 || ghist_0_o !== 5'd0) begin
			@(negedge clk);
			cycles++;
			if (cycles > 10) begin
				$display("Timed out waiting for the DUT to come out of reset");
				$display("ERRORS FOUND");
				$fatal(1);
			end
		end
	endtask

	////////////////////
	// Check and model update
	////////////////////

	task automatic check_and_update(input string name);
		logic [HIST_W-1:0] idx_0, idx_1, ui;
		logic [IDX_W-1:0]  ci;
		logic              jal_0, jal_1, br_0, br_1, jr_0, jr_1;
		logic              e_j0, e_j1, e_r0, e_r1, blk, c_0, c_1, rt_0, rt_1, e_pv, sel_ret;
		logic [31:0]       e_tgt, sel_pc;
		#10; // Mid-cycle, outputs settled
		jal_0 = instr_0_i[6:0] == OP_JAL;
		jal_1 = instr_1_i[6:0] == OP_JAL;
		br_0  = instr_0_i[6:0] == OP_BRANCH;
		br_1  = instr_1_i[6:0] == OP_BRANCH;
		jr_0  = instr_0_i[6:0] == OP_JALR;
		jr_1  = instr_1_i[6:0] == OP_JALR;
		idx_0 = pc_0_i[HIST_W+1:2] ^ m_ghist;
		idx_1 = pc_1_i[HIST_W+1:2] ^ m_ghist;
		e_j0  = base_valid_i && (jal_0 || (br_0 && m_pht[idx_0][1]));
		e_r0  = base_valid_i && jr_0;
		blk   = !base_valid_i || e_j0 || e_r0;
		e_j1  = !blk && (jal_1 || (br_1 && m_pht[idx_1][1]));
		e_r1  = !blk && jr_1;
		c_0   = base_valid_i && (jal_0 || jr_0) && link_reg(instr_0_i[11:7]);
		c_1   = !blk && (jal_1 || jr_1) && link_reg(instr_1_i[11:7]);
		rt_0  = e_r0 && link_reg(instr_0_i[19:15]) && (instr_0_i[11:7] == 5'd0);
		rt_1  = e_r1 && link_reg(instr_1_i[19:15]) && (instr_1_i[11:7] == 5'd0);
		sel_pc  = e_r0 ? pc_0_i : pc_1_i;
		sel_ret = e_r0 ? rt_0 : rt_1;
		ci      = sel_pc[IDX_W+1:2];
		e_pv    = 1'b0;
		e_tgt   = '0;
		if (e_r0 || e_r1) begin
			if (sel_ret && m_count > 0) begin
				e_pv  = 1'b1;
				e_tgt = m_stack[m_ptr];
			end else begin
				e_pv  = m_valid[ci] && (m_tag[ci] == sel_pc[31:IDX_W+2]);
				e_tgt = m_target[ci];
			end
		end
		compare_val({name, " jump_0"}, e_j0, jump_0_o);
		compare_val({name, " jump_1"}, e_j1, jump_1_o);
		compare_val({name, " jalr_0"}, e_r0, jalr_0_o);
		compare_val({name, " jalr_1"}, e_r1, jalr_1_o);
		compare_val({name, " ghist_0"}, m_ghist, ghist_0_o);
		compare_val({name, " ghist_1"}, m_ghist, ghist_1_o);
		compare_val({name, " jalr_pred_valid"}, e_pv, jalr_pred_valid_o);
		compare_val({name, " ras_tos"}, m_ptr, ras_tos_checkpoint_o);
		if (e_pv) compare_val({name, " jalr_pred_target"}, e_tgt, jalr_pred_target_o);

		// State the DUT takes on at the coming edge
		if (update_valid_i) begin
			ui        = update_pc_i[HIST_W+1:2] ^ update_ghist_i;
			m_pht[ui] = step_counter(m_pht[ui], update_taken_i);
			m_ghist   = {m_ghist[HIST_W-2:0], update_taken_i};
		end
		if (jalr_update_valid_i) begin
			ci           = jalr_update_pc_i[IDX_W+1:2];
			m_valid[ci]  = 1'b1;
			m_tag[ci]    = jalr_update_pc_i[31:IDX_W+2];
			m_target[ci] = correct_pc_i;
		end
		if (ras_restore_en_i) begin
			m_ptr = ras_restore_tos_i; // Wins over push and pop
		end else if (c_0 || c_1) begin
			m_ptr          = m_ptr + 3'd1;
			m_stack[m_ptr] = c_0 ? pc_0_i + 32'd4 : pc_1_i + 32'd4;
			if (m_count < 8) m_count++;
		end else if (rt_0 || rt_1) begin
			m_ptr = m_ptr - 3'd1;
			if (m_count > 0) m_count--;
		end
	endtask

	initial begin
		logic [31:0] pushed [$];
		logic [31:0] saved_target;
		logic [2:0]  saved_tos;
		void'($urandom(32'hd970));
		reset_i             = 1'b1;
		base_valid_i        = 1'b0;
		pc_0_i              = '0;
		pc_1_i              = '0;
		instr_0_i           = '0;
		instr_1_i           = '0;
		update_valid_i      = 1'b0;
		update_pc_i         = '0;
		update_taken_i      = 1'b0;
		update_ghist_i      = '0;
		jalr_update_valid_i = 1'b0;
		jalr_update_pc_i    = '0;
		correct_pc_i        = '0;
		ras_restore_en_i    = 1'b0;
		ras_restore_tos_i   = '0;
		for (int i = 0; i < 32; i++) m_pht[i] = WEAK_NT;
		for (int i = 0; i < 16; i++) m_valid[i] = 1'b0;
		m_ghist = '0;
		m_ptr   = '0;
		m_count = 0;
		repeat (8) @(negedge clk);
		reset_i = 1'b0;
		wait_reset_done();

		// Reset state
		next_cycle();
		random_fetch(1'b0);
		base_valid_i = 1'b0;
		check_and_update("reset_idle");
		repeat (8) begin
			next_cycle();
			random_fetch(1'b1);
			check_and_update("reset_branch");
		end

		// Direction training
		repeat (300) begin
			next_cycle();
			random_fetch(1'b1);
			random_resolve();
			jalr_update_valid_i = 1'b0;
			check_and_update("direction");
		end

		// Decode, blocking and indirect targets
		repeat (300) begin
			next_cycle();
			random_fetch(1'b0);
			random_resolve();
			check_and_update("decode");
		end
		repeat (200) begin
			next_cycle();
			random_resolve();
			base_valid_i = 1'b1;
			pc_0_i       = alias_pc();
			pc_1_i       = alias_pc();
			instr_0_i    = make_instr(($urandom % 2) ? OP_JALR : OP_OTHER, 5'd0, 5'd10);
			instr_1_i    = make_instr(OP_JALR, 5'd0, 5'd10); // Never a return
			check_and_update("indirect");
		end

		////////////////////
		// Calls and returns
		////////////////////

		for (int n = 1; n <= 6; n++) begin
			for (int k = 0; k < n; k++) begin
				next_cycle();
				fetch_call($urandom & 32'hffff_fffc, k % 2);
				pushed.push_back(pc_0_i + 32'd4);
				check_and_update("call");
			end
			for (int k = 0; k < n; k++) begin
				next_cycle();
				fetch_return($urandom & 32'hffff_fffc, (k % 2) ? LINK_X5 : LINK_X1);
				check_and_update("return");
				compare_val("return_lifo", pushed.pop_back(), jalr_pred_target_o);
			end
		end

		// Checkpoint after the third call, then restore over a call
		saved_target = '0;
		saved_tos    = '0;
		for (int k = 0; k < 5; k++) begin
			next_cycle();
			fetch_call($urandom & 32'hffff_fffc, 1'b0);
			check_and_update("checkpoint_call");
			if (k == 2) begin
				saved_target = pc_0_i + 32'd4;
				saved_tos    = m_ptr;
			end
		end
		next_cycle();
		fetch_call($urandom & 32'hffff_fffc, 1'b1);
		ras_restore_en_i  = 1'b1;
		ras_restore_tos_i = saved_tos;
		check_and_update("restore");
		next_cycle();
		fetch_return($urandom & 32'hffff_fffc, LINK_X1);
		check_and_update("restore_return");
		compare_val("restore_target", saved_target, jalr_pred_target_o);

		$display("NO ERRORS");
		$finish;
	end

endmodule
